// ==== verilog/dcache_pkg.sv ====
package dcache_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int WAYS       = 2;
    localparam int LINE_WORDS = 4;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 4;                          // 16 sets
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [ADDR_W-1:0]             addr_t;
    typedef logic [WORD_W-1:0]             word_t;
    typedef logic [TAG_W-1:0]              tag_t;
    typedef logic [INDEX_W-1:0]            index_t;
    typedef logic [$clog2(LINE_WORDS)-1:0] word_sel_t;
    typedef logic [$clog2(WAYS)-1:0]       way_t;
    typedef logic [WORD_W/8-1:0]           be_t;
    typedef logic [1:0]                    size_t;      // 0: 1 byte, 1: 2 bytes, 2: 4 bytes
    typedef logic [LINE_WORDS*WORD_W-1:0]  line_t;

    typedef struct packed {
        logic  wr;
        size_t size;
        addr_t addr;
        word_t wdata;   // data sits in the low bytes, the cache shifts it into place
    } cpu_req_t;

    // req is a level for the whole burst, wen marks a write burst
    typedef struct packed {
        logic  req;
        logic  wen;
        addr_t addr;    // line aligned
        word_t wdata;
        logic  wlast;
    } mem_cmd_t;

    typedef enum logic [1:0] {
        LOOKUP,
        WRITEBACK,
        REFILL,
        FILL_DONE
    } ctrl_state_e;

endpackage

// ==== verilog/dcache_burst_counter.sv ====
`timescale 1ns/100ps

module dcache_burst_counter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  step,
    output dcache_pkg::word_sel_t word_idx,
    output logic                  last
);
    import dcache_pkg::*;

    // the index wraps to 0 after the last step and is then ready for the
    // refill that follows a write-back
    always_ff @(posedge clk) begin
        if (rst)
            word_idx <= '0;
        else if (start)
            word_idx <= '0;
        else if (step)
            word_idx <= word_idx + 1'b1;
    end

    assign last = word_idx == word_sel_t'(LINE_WORDS - 1);

    // a burst never starts on the cycle a word moves
    assert property (@(posedge clk) disable iff (rst) !(start && step));

endmodule

// ==== verilog/dcache_way_store.sv ====
`timescale 1ns/100ps

module dcache_way_store (
    input  logic                  clk,
    input  logic                  rst,
    input  dcache_pkg::index_t    index,
    input  dcache_pkg::tag_t      tag_in,
    input  logic                  fill_we,
    input  dcache_pkg::word_sel_t fill_word_idx,
    input  dcache_pkg::word_t     fill_word,
    input  logic                  store_we,
    input  dcache_pkg::word_sel_t store_word_idx,
    input  dcache_pkg::be_t       store_be,
    input  dcache_pkg::word_t     store_word,
    output dcache_pkg::tag_t      tag_out,
    output logic                  valid_out,
    output logic                  dirty_out,
    output dcache_pkg::line_t     line_out
);
    import dcache_pkg::*;

    tag_t                  tag_mem  [2**INDEX_W];
    line_t                 line_mem [2**INDEX_W];
    logic [2**INDEX_W-1:0] valid_q;
    logic [2**INDEX_W-1:0] dirty_q;
    logic                  fill_last;

    assign fill_last = fill_we && fill_word_idx == word_sel_t'(LINE_WORDS - 1);

    always_ff @(posedge clk) begin
        if (fill_we)
            line_mem[index][fill_word_idx*WORD_W +: WORD_W] <= fill_word;
        if (store_we) begin
            for (int b = 0; b < WORD_W/8; b++) begin
                if (store_be[b])
                    line_mem[index][store_word_idx*WORD_W + b*8 +: 8] <= store_word[b*8 +: 8];
            end
        end
        if (fill_last)
            tag_mem[index] <= tag_in;   // tag goes in with the final word
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_last) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;     // fresh line matches memory
        end else if (store_we) begin
            dirty_q[index] <= 1'b1;
        end
    end

    assign tag_out   = tag_mem[index];
    assign valid_out = valid_q[index];
    assign dirty_out = dirty_q[index];
    assign line_out  = line_mem[index];

    // stores land only in a line that a hit found
    assert property (@(posedge clk) disable iff (rst) store_we |-> valid_q[index]);

    assert property (@(posedge clk) disable iff (rst) !(fill_we && store_we));

endmodule

// ==== verilog/dcache_lookup.sv ====
`timescale 1ns/100ps

module dcache_lookup (
    input  dcache_pkg::cpu_req_t                     cpu_in,
    input  dcache_pkg::tag_t  [dcache_pkg::WAYS-1:0] way_tags,
    input  logic              [dcache_pkg::WAYS-1:0] way_valids,
    input  logic              [dcache_pkg::WAYS-1:0] way_dirtys,
    input  dcache_pkg::line_t [dcache_pkg::WAYS-1:0] way_lines,
    input  dcache_pkg::way_t                         victim_way,
    input  dcache_pkg::word_sel_t                    word_idx,
    output logic                                     hit,
    output dcache_pkg::way_t                         hit_way,
    output dcache_pkg::word_t                        rd_word,
    output logic                                     victim_dirty,
    output dcache_pkg::tag_t                         victim_tag,
    output dcache_pkg::word_t                        victim_wdata,
    output dcache_pkg::be_t                          store_be,
    output dcache_pkg::word_t                        store_word
);
    import dcache_pkg::*;

    tag_t            req_tag;
    word_sel_t       req_word;
    logic [1:0]      byte_off;
    logic [WAYS-1:0] match;

    assign req_tag  = cpu_in.addr[ADDR_W-1 -: TAG_W];
    assign req_word = cpu_in.addr[OFFSET_W-1:2];
    assign byte_off = cpu_in.addr[1:0];

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            match[w] = way_valids[w] && way_tags[w] == req_tag;
            if (match[w])
                hit_way = way_t'(w);
        end
    end

    assign hit     = |match;
    assign rd_word = way_lines[hit_way][req_word*WORD_W +: WORD_W];  // whole aligned word

    assign victim_dirty = way_valids[victim_way] && way_dirtys[victim_way];
    assign victim_tag   = way_tags[victim_way];
    assign victim_wdata = way_lines[victim_way][word_idx*WORD_W +: WORD_W];

    always_comb begin
        case (cpu_in.size)
            2'd0:    store_be = be_t'(4'b0001) << byte_off;
            2'd1:    store_be = be_t'(4'b0011) << byte_off;   // halfword, aligned
            default: store_be = 4'b1111;
        endcase
    end

    assign store_word = cpu_in.wdata << {byte_off, 3'b000};

    // a line is only ever filled into one way
    always_comb begin
        assert ($isunknown(match) || $onehot0(match))
            else $error("tag matches in more than one way");
    end

endmodule

// ==== verilog/dcache_replace.sv ====
`timescale 1ns/100ps

module dcache_replace (
    input  logic               clk,
    input  logic               rst,
    input  dcache_pkg::index_t index,
    input  logic               fill_done,
    output dcache_pkg::way_t   victim_way
);
    import dcache_pkg::*;

    way_t ptr_q [2**INDEX_W];   // next way to evict, per set

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < 2**INDEX_W; s++)
                ptr_q[s] <= '0;
        end else if (fill_done) begin
            ptr_q[index] <= ptr_q[index] + 1'b1;    // wraps over the ways
        end
    end

    assign victim_way = ptr_q[index];

    // the request is held across the fill, so the same set moves on
    assert property (@(posedge clk) disable iff (rst)
        fill_done |=> victim_way != $past(victim_way));

endmodule

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/100ps

module dcache_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cpu_req,
    input  logic                 cpu_wr,
    input  logic                 hit,
    input  logic                 victim_dirty,
    input  dcache_pkg::addr_t    cpu_addr,
    input  dcache_pkg::tag_t     victim_tag,
    input  dcache_pkg::word_t    victim_wdata,
    input  logic                 last,
    input  logic                 mem_addr_ok,
    input  logic                 mem_data_ok,
    output dcache_pkg::mem_cmd_t mem_cmd,
    output logic                 fill_we,
    output logic                 store_we,
    output logic                 cnt_start,
    output logic                 cnt_step,
    output logic                 cpu_data_ok,
    output logic                 fill_done
);
    import dcache_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    logic        addr_done;     // line address already taken in this burst
    logic        burst_gap;     // one idle cycle between write-back and refill
    logic        in_burst;
    logic        lookup_hit;
    logic        lookup_miss;
    logic        burst_end;

    assign in_burst    = (state == WRITEBACK || state == REFILL) && !burst_gap;
    assign lookup_hit  = state == LOOKUP && cpu_req && hit;
    assign lookup_miss = state == LOOKUP && cpu_req && !hit;

    // data_ok only counts once the address has gone out
    assign cnt_step  = in_burst && mem_data_ok && (addr_done || mem_addr_ok);
    assign burst_end = cnt_step && last;
    assign cnt_start = lookup_miss;

    assign cpu_data_ok = lookup_hit;
    assign store_we    = lookup_hit && cpu_wr;
    assign fill_we     = state == REFILL && cnt_step;
    assign fill_done   = state == FILL_DONE;

    always_comb begin
        state_nxt = state;
        case (state)
            LOOKUP: begin
                if (lookup_miss)
                    state_nxt = victim_dirty ? WRITEBACK : REFILL;
            end
            WRITEBACK: begin
                if (burst_end)
                    state_nxt = REFILL;
            end
            REFILL: begin
                if (burst_end)
                    state_nxt = FILL_DONE;
            end
            default: state_nxt = LOOKUP;   // FILL_DONE goes back to retry as a hit
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= LOOKUP;
            addr_done <= 1'b0;
            burst_gap <= 1'b0;
        end else begin
            state     <= state_nxt;
            burst_gap <= state == WRITEBACK && burst_end;
            if (burst_end)
                addr_done <= 1'b0;
            else if (in_burst && mem_addr_ok)
                addr_done <= 1'b1;
        end
    end

    always_comb begin
        mem_cmd       = '0;
        mem_cmd.req   = in_burst;
        mem_cmd.wen   = in_burst && state == WRITEBACK;
        mem_cmd.wlast = mem_cmd.wen && last;
        mem_cmd.wdata = victim_wdata;
        if (state == WRITEBACK)
            mem_cmd.addr = {victim_tag, cpu_addr[OFFSET_W +: INDEX_W], {OFFSET_W{1'b0}}};
        else
            mem_cmd.addr = {cpu_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    end

    // the command holds still while the memory stalls
    assert property (@(posedge clk) disable iff (rst)
        mem_cmd.req && !burst_end |=> mem_cmd.req && $stable(mem_cmd.addr)
            && $stable(mem_cmd.wen));

    // the refilled line hits before the retry
    assert property (@(posedge clk) disable iff (rst) state == FILL_DONE |-> hit);

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cpu_req,
    input  dcache_pkg::cpu_req_t cpu_in,
    output logic                 cpu_data_ok,
    output dcache_pkg::word_t    cpu_rdata,
    output dcache_pkg::mem_cmd_t mem_cmd,
    input  dcache_pkg::word_t    mem_rdata,
    input  logic                 mem_addr_ok,
    input  logic                 mem_data_ok
);
    import dcache_pkg::*;

    index_t           req_index;
    tag_t             req_tag;
    word_sel_t        req_word;
    tag_t  [WAYS-1:0] way_tags;
    logic  [WAYS-1:0] way_valids;
    logic  [WAYS-1:0] way_dirtys;
    line_t [WAYS-1:0] way_lines;
    logic             hit;
    way_t             hit_way;
    way_t             victim_way;
    logic             victim_dirty;
    tag_t             victim_tag;
    word_t            victim_wdata;
    be_t              store_be;
    word_t            store_word;
    logic             fill_we;
    logic             store_we;
    logic             fill_done;
    logic             cnt_start;
    logic             cnt_step;
    word_sel_t        word_idx;
    logic             last;

    assign req_tag   = cpu_in.addr[ADDR_W-1 -: TAG_W];
    assign req_index = cpu_in.addr[OFFSET_W +: INDEX_W];
    assign req_word  = cpu_in.addr[OFFSET_W-1:2];

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .cpu_wr       (cpu_in.wr),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .cpu_addr     (cpu_in.addr),
        .victim_tag   (victim_tag),
        .victim_wdata (victim_wdata),
        .last         (last),
        .mem_addr_ok  (mem_addr_ok),
        .mem_data_ok  (mem_data_ok),
        .mem_cmd      (mem_cmd),
        .fill_we      (fill_we),
        .store_we     (store_we),
        .cnt_start    (cnt_start),
        .cnt_step     (cnt_step),
        .cpu_data_ok  (cpu_data_ok),
        .fill_done    (fill_done)
    );

    dcache_burst_counter u_cnt (
        .clk      (clk),
        .rst      (rst),
        .start    (cnt_start),
        .step     (cnt_step),
        .word_idx (word_idx),
        .last     (last)
    );

    dcache_lookup u_lookup (
        .cpu_in       (cpu_in),
        .way_tags     (way_tags),
        .way_valids   (way_valids),
        .way_dirtys   (way_dirtys),
        .way_lines    (way_lines),
        .victim_way   (victim_way),
        .word_idx     (word_idx),
        .hit          (hit),
        .hit_way      (hit_way),
        .rd_word      (cpu_rdata),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_wdata (victim_wdata),
        .store_be     (store_be),
        .store_word   (store_word)
    );

    dcache_replace u_replace (
        .clk        (clk),
        .rst        (rst),
        .index      (req_index),
        .fill_done  (fill_done),
        .victim_way (victim_way)
    );

    // refill goes to the victim, stores to the hit way
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        dcache_way_store u_way (
            .clk            (clk),
            .rst            (rst),
            .index          (req_index),
            .tag_in         (req_tag),
            .fill_we        (fill_we && victim_way == way_t'(w)),
            .fill_word_idx  (word_idx),
            .fill_word      (mem_rdata),
            .store_we       (store_we && hit_way == way_t'(w)),
            .store_word_idx (req_word),
            .store_be       (store_be),
            .store_word     (store_word),
            .tag_out        (way_tags[w]),
            .valid_out      (way_valids[w]),
            .dirty_out      (way_dirtys[w]),
            .line_out       (way_lines[w])
        );
    end

endmodule

// ==== dv/dcache_mem_model.sv ====
`timescale 1ns/100ps

module dcache_mem_model (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::mem_cmd_t mem_cmd,
    output dcache_pkg::word_t    mem_rdata,
    output logic                 mem_addr_ok,
    output logic                 mem_data_ok
);
    import dcache_pkg::*;

    word_t      mem [1024];     // 4 KB, word addressed
    logic [7:0] base;           // line number of the burst
    logic       wen;

    initial begin
        for (int i = 0; i < 1024; i++)
            mem[10'(i)] = (32'(i) * 32'h9e37_79b1) ^ 32'h0bad_c0de;
        mem_rdata   = '0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && mem_cmd.req) begin
                base = mem_cmd.addr[11:4];
                wen  = mem_cmd.wen;
                repeat ($urandom % 4) @(negedge clk);
                mem_addr_ok = 1'b1;
                @(negedge clk);
                mem_addr_ok = 1'b0;
                for (int beat = 0; beat < LINE_WORDS; beat++) begin
                    repeat ($urandom % 4) @(negedge clk);
                    if (wen)
                        mem[{base, 2'(beat)}] = mem_cmd.wdata;  // word at the counter
                    else
                        mem_rdata = mem[{base, 2'(beat)}];
                    mem_data_ok = 1'b1;
                    @(negedge clk);
                    mem_data_ok = 1'b0;
                end
            end
        end
    end

endmodule

// ==== dv/dcache_tb.sv ====
`timescale 1ns/100ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int N_RANDOM    = 300;
    localparam int N_REQS      = N_RANDOM + 14 + 7 + 32;
    localparam int WATCHDOG_NS = (N_REQS * 40 + 10) * CLK_PERIOD;
    localparam logic [27:0] RR_TAGS = 28'h4565465;  // tag order into one set

    logic     clk;
    logic     rst;
    logic     cpu_req;
    cpu_req_t cpu_in;
    logic     cpu_data_ok;
    word_t    cpu_rdata;
    mem_cmd_t mem_cmd;
    word_t    mem_rdata;
    logic     mem_addr_ok;
    logic     mem_data_ok;

    logic [7:0]  shadow    [4096];
    tag_t        ref_tag   [16][WAYS];
    logic [1:0]  ref_valid [16];
    logic [1:0]  ref_dirty [16];
    way_t        ref_ptr   [16];
    logic [32:0] seen_bursts [$];   // {wen, addr}
    logic [32:0] exp_bursts  [$];

    dcache_top UUT (.*);
    dcache_mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the cache stopped completing requests");
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic word_t ref_load(input addr_t addr);
        logic [11:0] a;
        a = {addr[11:2], 2'b00};
        return {shadow[a + 12'd3], shadow[a + 12'd2], shadow[a + 12'd1], shadow[a]};
    endfunction

    function automatic addr_t byte_addr(input logic [3:0] tag, input index_t set,
                                        input word_sel_t word, input logic [1:0] off);
        return {20'h0, tag, set, word, off};
    endfunction

    task automatic access(input logic wr, input size_t size, input addr_t addr, input word_t wdata);
        index_t idx;
        tag_t   tag;
        way_t   way;
        logic   hit;
        logic   done;
        logic   prev_req;
        logic   wr_burst;
        int     beat;
        idx = addr[OFFSET_W +: INDEX_W];
        tag = addr[ADDR_W-1 -: TAG_W];
        hit = 1'b0;
        way = '0;
        wr_burst = 1'b0;
        beat     = 0;
        exp_bursts.delete();
        seen_bursts.delete();
        for (int w = 0; w < WAYS; w++) begin
            if (ref_valid[idx][way_t'(w)] && ref_tag[idx][w] == tag) begin
                hit = 1'b1;
                way = way_t'(w);
            end
        end
        if (!hit) begin
            way = ref_ptr[idx];
            if (ref_valid[idx][way] && ref_dirty[idx][way])
                exp_bursts.push_back({1'b1, ref_tag[idx][way], idx, 4'h0});
            exp_bursts.push_back({1'b0, tag, idx, 4'h0});
            ref_tag[idx][way]   = tag;
            ref_valid[idx][way] = 1'b1;
            ref_dirty[idx][way] = 1'b0;
            ref_ptr[idx]        = ref_ptr[idx] + 1'b1;
        end
        if (wr)
            ref_dirty[idx][way] = 1'b1;

        #1;     // idle cycle where nothing moves without a request
        check_equal("cpu_data_ok", 32'(cpu_data_ok), 32'd0);
        check_equal("mem_cmd.req", 32'(mem_cmd.req), 32'd0);
        @(negedge clk);
        cpu_req      = 1'b1;
        cpu_in.wr    = wr;
        cpu_in.size  = size;
        cpu_in.addr  = addr;
        cpu_in.wdata = wdata;
        done     = 1'b0;
        prev_req = 1'b0;
        while (!done) begin
            #1;
            if (mem_cmd.req && !prev_req) begin
                seen_bursts.push_back({mem_cmd.wen, mem_cmd.addr});
                wr_burst = seen_bursts.size() <= exp_bursts.size()
                           && exp_bursts[seen_bursts.size() - 1][32];
                beat     = 0;
            end
            // wlast only on the fourth word of a write-back
            if (mem_cmd.req && mem_data_ok) begin
                check_equal("mem_cmd.wlast", 32'(mem_cmd.wlast),
                            32'(wr_burst && beat == LINE_WORDS - 1));
                beat++;
            end
            prev_req = mem_cmd.req;
            if (cpu_data_ok) begin
                done = 1'b1;
                if (!wr)
                    check_equal("cpu_rdata", cpu_rdata, ref_load(addr));
            end
            @(negedge clk);
        end
        cpu_req = 1'b0;
        if (wr) begin
            for (int b = 0; b < (1 << size); b++)
                shadow[addr[11:0] + 12'(b)] = wdata[8*b +: 8];
        end
        check_equal("burst count", 32'(seen_bursts.size()), 32'(exp_bursts.size()));
        foreach (exp_bursts[i]) begin
            check_equal("mem_cmd.wen", 32'(seen_bursts[i][32]), 32'(exp_bursts[i][32]));
            check_equal("mem_cmd.addr", seen_bursts[i][31:0], exp_bursts[i][31:0]);
        end
    endtask

    initial begin
        size_t      size;
        logic [1:0] off;
        void'($urandom(32'hf04a));
        rst     = 1'b1;
        cpu_req = 1'b0;
        cpu_in  = '0;
        for (int s = 0; s < 16; s++) begin
            ref_valid[s] = '0;
            ref_dirty[s] = '0;
            ref_ptr[s]   = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            for (int b = 0; b < 4; b++)
                shadow[12'(i*4 + b)] = u_mem.mem[10'(i)][8*b +: 8];
        end

        // small window of 4 tags over 4 sets so lines keep evicting each other
        for (int n = 0; n < N_RANDOM; n++) begin
            size = size_t'($urandom % 3);
            off  = 2'($urandom);
            if (size == 2'd1)
                off[0] = 1'b0;
            else if (size == 2'd2)
                off = 2'b00;
            access(1'($urandom), size,
                   byte_addr({2'b00, 2'($urandom)}, {2'b00, 2'($urandom)}, 2'($urandom), off),
                   $urandom);
        end

        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o < 4; o += (1 << s)) begin
                access(1'b1, size_t'(s), byte_addr(4'h1, 4'h5, 2'd2, 2'(o)), $urandom);
                access(1'b0, 2'd2, byte_addr(4'h1, 4'h5, 2'd2, 2'b00), '0);
            end
        end

        // the first one stores so the third access writes it back
        for (int k = 0; k < 7; k++)
            access(k == 0, 2'd2, byte_addr(RR_TAGS[4*(6-k) +: 4], 4'h9, '0, '0), $urandom);

        for (int s = 0; s < 16; s++) begin
            access(1'b0, 2'd2, byte_addr(4'hc, index_t'(s), '0, '0), '0);
            access(1'b0, 2'd2, byte_addr(4'hd, index_t'(s), '0, '0), '0);
        end

        for (int i = 0; i < 1024; i++)
            check_equal($sformatf("mem[%03h]", i*4), u_mem.mem[10'(i)], ref_load(addr_t'(i*4)));
        $display("sim passed");
        $finish;
    end

endmodule

// ==== list.f ====
verilog/dcache_pkg.sv
verilog/dcache_burst_counter.sv
verilog/dcache_way_store.sv
verilog/dcache_lookup.sv
verilog/dcache_replace.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f list.f --top-module dcache_tb -o dcache_sim

out=$(./obj_dir/dcache_sim) || true
echo "$out"
echo "$out" | grep -q "sim passed"
